// ==== cnn_conv_top.f ====
+incdir+source
source/cnn_data_pkg.sv
source/cnn_ctrl_pkg.sv
source/cnn_window_gen.sv
source/cnn_kernel.sv
source/cnn_result_fifo.sv
source/cnn_output_stage.sv
source/cnn_conv_top.sv
dv/cnn_conv_assertions.sv
dv/cnn_conv_tb.sv

// ==== Bender.yml ====
package:
  name: cnn_conv

export_include_dirs:
  - source

sources:
  # Packages first, then the datapath blocks and the top level
  - files:
      - source/cnn_data_pkg.sv
      - source/cnn_ctrl_pkg.sv
      - source/cnn_window_gen.sv
      - source/cnn_kernel.sv
      - source/cnn_result_fifo.sv
      - source/cnn_output_stage.sv
      - source/cnn_conv_top.sv

  # Verification sources
  - target: test
    include_dirs:
      - source
    files:
      - dv/cnn_conv_assertions.sv
      - dv/cnn_conv_tb.sv

// ==== dv/cnn_conv_stimulus.txt ====
// Hex words in load order: 25 weights row-major (signed 8 bit), bias (signed 16 bit),
// 128 pixels as two 8x8 frames in raster order (signed 8 bit), 32 expected outputs
10 1E 2C 3A 48
0A 18 26 34 42
04 12 20 2E 3C
FE 0C 1A 28 36
F8 06 14 22 30
C950
00 01 02 03 04 05 06 07
08 09 0A 0B 0C 0D 0E 0F
10 11 12 13 14 15 16 17
18 19 1A 1B 1C 1D 1E 1F
20 21 22 23 24 25 26 27
28 29 2A 2B 2C 2D 2E 2F
30 31 32 33 34 35 36 37
38 39 3A 3B 3C 3D 3E 3F
F0 F8 00 08 10 18 20 28
F1 F9 01 09 11 19 21 29
F2 FA 02 0A 12 1A 22 2A
F3 FB 03 0B 13 1B 23 2B
F4 FC 04 0C 14 1C 24 2C
F5 FD 05 0D 15 1D 25 2D
F6 FE 06 0E 16 1E 26 2E
F7 FF 07 0F 17 1F 27 2F
00 00 04 11 4F 5C 68 75
B3 C0 CC D9 FF FF FF FF
00 00 59 BD 00 01 65 C9
00 0E 72 D6 00 1A 7E E2

// ==== dv/cnn_conv_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cnn_conv_defines.svh"

module cnn_conv_tb;

    import cnn_data_pkg::*;

    localparam int TAPS         = `CNN_KX * `CNN_KY;
    localparam int BIAS_IDX     = TAPS;
    localparam int PIX_BASE     = TAPS + 1;
    localparam int N_PIX        = 2 * `CNN_IMG_W * `CNN_IMG_H;   // Two frames
    localparam int EXP_BASE     = PIX_BASE + N_PIX;
    localparam int N_RES        = 2 * (`CNN_IMG_W - `CNN_KX + 1) * (`CNN_IMG_H - `CNN_KY + 1);
    localparam int STIM_WORDS   = EXP_BASE + N_RES;
    localparam int WAIT_LIMIT   = 400;
    localparam int STALL_AT     = 3;
    localparam int STALL_CYCLES = 40;
    localparam int PORT_PIX_ACK = 0;
    localparam int PORT_RES_REQ = 1;

    logic     clk;
    logic     reset_n;
    weights_t weights;
    bias_t    bias;
    logic     pix_req;
    pixel_t   pix_data;
    logic     pix_ack;
    logic     res_req;
    result_t  res_data;
    logic     res_ack;

    logic [15:0] stim_mem [STIM_WORDS];
    integer      seed;
    int          check_count;
    int          error_count;
    int          timeout_count;
    int          stall_refusals;   // Cycles the source waited on a withheld ack
    int          res_count;
    logic        timed_out;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    cnn_conv_top dut_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_weights  (weights),
        .i_bias     (bias),
        .i_pix_req  (pix_req),
        .i_pix_data (pix_data),
        .o_pix_ack  (pix_ack),
        .o_res_req  (res_req),
        .o_res_data (res_data),
        .i_res_ack  (res_ack)
    );

    // ========================================================================
    // Handshake helpers
    // ========================================================================
    function automatic logic port_level(input int which);
        if (which == PORT_PIX_ACK) begin
            port_level = pix_ack;
        end else begin
            port_level = res_req;
        end
    endfunction

    // Polls on falling edges until the level shows or any wait has timed out
    task automatic wait_for_level(input int which, input logic level, input string what);
        int cycles;
        cycles = 0;
        while (port_level(which) !== level && cycles < WAIT_LIMIT && !timed_out) begin
            @(negedge clk);
            cycles++;
        end
        if (port_level(which) !== level && !timed_out) begin
            timed_out = 1'b1;
            timeout_count++;
            $display("Timeout at %0t: %s did not come within %0d cycles", $time, what,
                     WAIT_LIMIT);
        end
    endtask

    task automatic send_pixel(input pixel_t value);
        pix_data <= value;
        pix_req  <= 1'b1;
        wait_for_level(PORT_PIX_ACK, 1'b1, "pixel ack");
        pix_req  <= 1'b0;
        wait_for_level(PORT_PIX_ACK, 1'b0, "pixel ack release");
    endtask

    task automatic drive_pixels();
        int i;
        for (i = 0; i < N_PIX && !timed_out; i++) begin
            send_pixel(pixel_t'(stim_mem[PIX_BASE + i][`CNN_PIX_BW-1:0]));
        end
    endtask

    // ========================================================================
    // Result side
    // ========================================================================
    task automatic check_result(input int idx, input result_t value);
        result_t expected;
        expected = result_t'(stim_mem[EXP_BASE + idx][`CNN_OUT_BW-1:0]);
        check_count++;
        if (value !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: result %0d is %0d, expected %0d", $time, idx,
                     value, expected);
        end
    endtask

    task automatic hold_consumer(input int cycles);
        int k;
        for (k = 0; k < cycles; k++) begin
            @(negedge clk);
            if (pix_req === 1'b1 && pix_ack === 1'b0) begin
                stall_refusals++;
            end
        end
    endtask

    task automatic answer_results();
        int idx;
        int delay;
        for (idx = 0; idx < N_RES && !timed_out; idx++) begin
            wait_for_level(PORT_RES_REQ, 1'b1, "result req");
            if (!timed_out) begin
                check_result(idx, res_data);
                if (idx == STALL_AT) begin
                    hold_consumer(STALL_CYCLES);   // Lets the FIFO fill up
                end else begin
                    delay = {$random(seed)} % 7;
                    repeat (delay) @(negedge clk);
                end
                res_ack <= 1'b1;
                wait_for_level(PORT_RES_REQ, 1'b0, "result req release");
                res_ack <= 1'b0;
                res_count++;
            end
        end
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        int   k;
        logic extra_req;
        seed           = 32'hf40d;
        check_count    = 0;
        error_count    = 0;
        timeout_count  = 0;
        stall_refusals = 0;
        res_count      = 0;
        timed_out      = 1'b0;
        extra_req      = 1'b0;
        reset_n        = 1'b0;
        pix_req        = 1'b0;
        pix_data       = '0;
        res_ack        = 1'b0;
        weights        = '0;
        bias           = '0;

        $readmemh("dv/cnn_conv_stimulus.txt", stim_mem);
        if ($isunknown(stim_mem[STIM_WORDS-1])) begin
            error_count++;
            $display("Stimulus file dv/cnn_conv_stimulus.txt is missing or too short");
        end
        for (k = 0; k < TAPS; k++) begin
            weights.w[k] = weight_t'(stim_mem[k][`CNN_W_BW-1:0]);
        end
        bias = bias_t'(stim_mem[BIAS_IDX]);

        repeat (8) @(negedge clk);
        reset_n <= 1'b1;

        // Both ports quiet with no stimulus
        for (k = 0; k < 10; k++) begin
            @(negedge clk);
            check_count++;
            if (pix_ack !== 1'b0 || res_req !== 1'b0) begin
                error_count++;
                $display("CHECK FAILED at %0t: ack or req active before any stimulus", $time);
            end
        end

        fork
            drive_pixels();
            answer_results();
        join

        if (!timed_out) begin
            for (k = 0; k < 60; k++) begin
                @(negedge clk);
                if (res_req !== 1'b0) begin
                    extra_req = 1'b1;   // Duplicate or spurious result
                end
            end
        end

        check_count += 3;
        if (extra_req) begin
            error_count++;
            $display("CHECK FAILED at %0t: result req after the last result", $time);
        end
        if (res_count != N_RES) begin
            error_count++;
            $display("CHECK FAILED at %0t: got %0d results, expected %0d", $time, res_count,
                     N_RES);
        end
        if (stall_refusals == 0) begin
            error_count++;
            $display("CHECK FAILED at %0t: source never refused during consumer stall", $time);
        end

        $display("Summary: %0d checks, %0d errors, %0d timeouts, %0d assertion failures",
                 check_count, error_count, timeout_count, dut_i.assertions_i.violations);
        if (error_count == 0 && timeout_count == 0 &&
            dut_i.assertions_i.violations == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/cnn_conv_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cnn_conv_defines.svh"

module cnn_conv_assertions (
    input logic clk,
    input logic reset_n,
    input logic i_pix_req,
    input logic i_pix_ack,
    input logic i_res_req,
    input logic i_res_ack,
    input logic i_win_valid,
    input logic i_sum_valid
);

    int violations = 0;

    // ========================================================================
    // Four-phase handshakes
    // ========================================================================

    // Source may drop req in the cycle after ack rises
    pix_req_held: assert property (@(posedge clk) disable iff (!reset_n)
        i_pix_req && !i_pix_ack |=> i_pix_req || i_pix_ack)
        else begin
            violations++;
            $error("Pixel req dropped before ack");
        end

    pix_ack_release: assert property (@(posedge clk) disable iff (!reset_n)
        !i_pix_req && i_pix_ack |=> !i_pix_ack)
        else begin
            violations++;
            $error("Pixel ack still high after req went low");
        end

    res_req_held: assert property (@(posedge clk) disable iff (!reset_n)
        i_res_req && !i_res_ack |=> i_res_req)
        else begin
            violations++;
            $error("Result req dropped before ack");
        end

    res_ack_release: assert property (@(posedge clk) disable iff (!reset_n)
        !i_res_req && i_res_ack |=> !i_res_ack)
        else begin
            violations++;
            $error("Result ack still high after req went low");
        end

    // ========================================================================
    // Kernel latency
    // ========================================================================
    sum_after_window: assert property (@(posedge clk) disable iff (!reset_n)
        i_win_valid |-> ##(`CNN_KERNEL_LAT) i_sum_valid)
        else begin
            violations++;
            $error("Sum valid missing after window valid");
        end

    sum_has_window: assert property (@(posedge clk) disable iff (!reset_n)
        i_sum_valid |-> $past(i_win_valid, `CNN_KERNEL_LAT))
        else begin
            violations++;
            $error("Sum valid without a window two cycles earlier");
        end

endmodule

bind cnn_conv_top cnn_conv_assertions assertions_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_pix_req   (i_pix_req),
    .i_pix_ack   (o_pix_ack),
    .i_res_req   (o_res_req),
    .i_res_ack   (i_res_ack),
    .i_win_valid (win_valid),
    .i_sum_valid (sum_valid)
);

`default_nettype wire

// ==== source/cnn_conv_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cnn_conv_top (
    input  logic                   clk,
    input  logic                   reset_n,
    input  cnn_data_pkg::weights_t i_weights,
    input  cnn_data_pkg::bias_t    i_bias,
    input  logic                   i_pix_req,
    input  cnn_data_pkg::pixel_t   i_pix_data,
    output logic                   o_pix_ack,
    output logic                   o_res_req,
    output cnn_data_pkg::result_t  o_res_data,
    input  logic                   i_res_ack
);

    import cnn_data_pkg::*;
    import cnn_ctrl_pkg::*;

    logic         win_valid;
    window_t      window;
    logic         sum_valid;
    acc_t         sum;
    acc_t         fifo_head;
    fifo_status_t fifo_status;
    logic         pop;

    // ========================================================================
    // Producer, kernel, buffer, consumer
    // ========================================================================
    cnn_window_gen window_gen_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_pix_req     (i_pix_req),
        .i_pix_data    (i_pix_data),
        .i_fifo_status (fifo_status),
        .i_sum_valid   (sum_valid),      // Retires a window in flight
        .o_pix_ack     (o_pix_ack),
        .o_win_valid   (win_valid),
        .o_window      (window)
    );

    cnn_kernel kernel_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .i_cnn_weight    (i_weights),
        .i_in_valid      (win_valid),
        .i_in_fmap       (window),
        .o_ot_valid      (sum_valid),
        .o_ot_kernel_acc (sum)
    );

    cnn_result_fifo #(
        .DEPTH (8)
    ) result_fifo_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_push      (sum_valid),
        .i_push_data (sum),
        .i_pop       (pop),
        .o_head      (fifo_head),
        .o_status    (fifo_status)
    );

    cnn_output_stage output_stage_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_bias        (i_bias),
        .i_head        (fifo_head),
        .i_fifo_status (fifo_status),
        .i_res_ack     (i_res_ack),
        .o_pop         (pop),
        .o_res_req     (o_res_req),
        .o_res_data    (o_res_data)
    );

endmodule

`default_nettype wire

// ==== source/cnn_output_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cnn_conv_defines.svh"

module cnn_output_stage (
    input  logic                       clk,
    input  logic                       reset_n,
    input  cnn_data_pkg::bias_t        i_bias,
    input  cnn_data_pkg::acc_t         i_head,
    input  cnn_ctrl_pkg::fifo_status_t i_fifo_status,
    input  logic                       i_res_ack,
    output logic                       o_pop,
    output logic                       o_res_req,
    output cnn_data_pkg::result_t      o_res_data
);

    import cnn_data_pkg::*;
    import cnn_ctrl_pkg::*;

    localparam int SUM_BW = `CNN_ACC_BW + 1;

    res_hs_e                  state;
    logic signed [SUM_BW-1:0] biased;
    logic signed [SUM_BW-1:0] scaled;
    result_t                  clamped;
    result_t                  res_q;

    // ========================================================================
    // Bias, scale, ReLU and saturation
    // ========================================================================
    always_comb begin
        biased = SUM_BW'(i_head) + SUM_BW'(i_bias);
        scaled = biased >>> `CNN_OUT_SHIFT;
        if (scaled < 0) begin
            clamped = '0;                                     // ReLU
        end else if (scaled > SUM_BW'(2**`CNN_OUT_BW - 1)) begin
            clamped = '1;                                     // Saturate high
        end else begin
            clamped = result_t'(scaled);
        end
    end

    // ========================================================================
    // Output four-phase handshake
    // ========================================================================
    assign o_pop = (state == RES_IDLE) && !i_fifo_status.empty;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= RES_IDLE;
        end else begin
            case (state)
                RES_IDLE:    if (o_pop) state <= RES_REQ;
                RES_REQ:     if (i_res_ack) state <= RES_RELEASE;
                RES_RELEASE: if (!i_res_ack) state <= RES_IDLE;
                default:     state <= RES_IDLE;
            endcase
        end
    end

    // Result captured as the head is popped
    always_ff @(posedge clk) begin
        if (o_pop) begin
            res_q <= clamped;
        end
    end

    assign o_res_req  = (state == RES_REQ);
    assign o_res_data = res_q;

endmodule

`default_nettype wire

// ==== source/cnn_result_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module cnn_result_fifo #(
    parameter int DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       i_push,
    input  cnn_data_pkg::acc_t         i_push_data,
    input  logic                       i_pop,
    output cnn_data_pkg::acc_t         o_head,
    output cnn_ctrl_pkg::fifo_status_t o_status
);

    import cnn_data_pkg::*;
    import cnn_ctrl_pkg::*;

    localparam int PTR_BW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    acc_t              mem [DEPTH];
    logic [PTR_BW-1:0] wr_ptr;
    logic [PTR_BW-1:0] rd_ptr;
    fifo_cnt_t         count;
    logic              do_push;
    logic              do_pop;

    assign do_push = i_push && (count != fifo_cnt_t'(DEPTH));
    assign do_pop  = i_pop && (count != '0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_BW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_BW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    assign o_head         = mem[rd_ptr];   // Valid whenever not empty
    assign o_status.free  = fifo_cnt_t'(DEPTH) - count;
    assign o_status.empty = (count == '0);

endmodule

`default_nettype wire

// ==== source/cnn_kernel.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cnn_conv_defines.svh"

module cnn_kernel (
    input  logic                   clk,
    input  logic                   reset_n,
    input  cnn_data_pkg::weights_t i_cnn_weight,
    input  logic                   i_in_valid,
    input  cnn_data_pkg::window_t  i_in_fmap,
    output logic                   o_ot_valid,
    output cnn_data_pkg::acc_t     o_ot_kernel_acc
);

    import cnn_data_pkg::*;

    localparam int TAPS = `CNN_KX * `CNN_KY;

    logic [`CNN_KERNEL_LAT-1:0] valid_sr;
    product_t                   prod [TAPS];
    acc_t                       tap_sum;
    acc_t                       acc_q;

    // ========================================================================
    // Valid pipeline
    // ========================================================================

    // One stage for the multiply, one for the adder tree
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[`CNN_KERNEL_LAT-2:0], i_in_valid};
        end
    end

    // ========================================================================
    // Products, window times weights
    // ========================================================================
    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            for (int i = 0; i < TAPS; i++) begin
                prod[i] <= product_t'(i_in_fmap.px[i]) * product_t'(i_cnn_weight.w[i]);
            end
        end
    end

    // ========================================================================
    // Sum of the 25 products
    // ========================================================================
    always_comb begin
        tap_sum = '0;
        for (int i = 0; i < TAPS; i++) begin
            tap_sum = tap_sum + acc_t'(prod[i]);   // Sign extended
        end
    end

    always_ff @(posedge clk) begin
        if (valid_sr[0]) begin
            acc_q <= tap_sum;
        end
    end

    assign o_ot_valid      = valid_sr[`CNN_KERNEL_LAT-1];
    assign o_ot_kernel_acc = acc_q;

endmodule

`default_nettype wire

// ==== source/cnn_window_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cnn_conv_defines.svh"

module cnn_window_gen (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       i_pix_req,
    input  cnn_data_pkg::pixel_t       i_pix_data,
    input  cnn_ctrl_pkg::fifo_status_t i_fifo_status,
    input  logic                       i_sum_valid,
    output logic                       o_pix_ack,
    output logic                       o_win_valid,
    output cnn_data_pkg::window_t      o_window
);

    import cnn_data_pkg::*;
    import cnn_ctrl_pkg::*;

    localparam int COL_BW    = $clog2(`CNN_IMG_W);
    localparam int ROW_BW    = $clog2(`CNN_IMG_H);
    localparam int ROWS_HELD = `CNN_KY - 1;

    pix_hs_e           pix_state;
    logic [COL_BW-1:0] col;
    logic [ROW_BW-1:0] row;
    logic [1:0]        in_flight;    // Windows not yet pushed into the FIFO
    logic [4:0]        free_ext;
    logic [4:0]        need;
    logic              accept;
    logic              completes;

    pixel_t  line_buf [ROWS_HELD][`CNN_IMG_W];
    pixel_t  new_col [`CNN_KY];
    window_t win_q;

    // =======================================================================
    // Input handshake and back-pressure
    // =======================================================================
    assign free_ext  = {1'b0, i_fifo_status.free};
    assign need      = {3'b000, in_flight} + 5'd3;
    assign accept    = (pix_state == PIX_IDLE) && i_pix_req && (free_ext >= need);
    assign completes = (row >= ROW_BW'(`CNN_KY - 1)) && (col >= COL_BW'(`CNN_KX - 1));
    assign o_pix_ack = (pix_state == PIX_ACK);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pix_state   <= PIX_IDLE;
            col         <= '0;
            row         <= '0;
            in_flight   <= '0;
            o_win_valid <= 1'b0;
        end else begin
            case (pix_state)
                PIX_IDLE: begin
                    if (accept) begin
                        pix_state <= PIX_ACK;
                    end
                end
                PIX_ACK: begin
                    if (!i_pix_req) begin
                        pix_state <= PIX_IDLE;   // Source released, drop ack
                    end
                end
                default: pix_state <= PIX_IDLE;
            endcase

            // Raster position, wraps into the next frame
            if (accept) begin
                if (col == COL_BW'(`CNN_IMG_W - 1)) begin
                    col <= '0;
                    row <= (row == ROW_BW'(`CNN_IMG_H - 1)) ? '0 : row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end

            o_win_valid <= accept && completes;

            case ({o_win_valid, i_sum_valid})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    // =======================================================================
    // Line buffers and 5x5 shift window
    // =======================================================================

    // Column entering the window, oldest row first
    always_comb begin
        for (int r = 0; r < ROWS_HELD; r++) begin
            new_col[r] = line_buf[r][col];
        end
        new_col[ROWS_HELD] = i_pix_data;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int r = 0; r < ROWS_HELD; r++) begin
                line_buf[r][col] <= new_col[r+1];   // Each row moves up one
            end
            for (int r = 0; r < `CNN_KY; r++) begin
                for (int c = 0; c < `CNN_KX - 1; c++) begin
                    win_q.px[r*`CNN_KX + c] <= win_q.px[r*`CNN_KX + c + 1];
                end
                win_q.px[r*`CNN_KX + `CNN_KX - 1] <= new_col[r];
            end
        end
    end

    assign o_window = win_q;

endmodule

`default_nettype wire

// ==== source/cnn_ctrl_pkg.sv ====
`default_nettype none

package cnn_ctrl_pkg;

    // Input side four-phase states
    typedef enum logic [0:0] {
        PIX_IDLE,
        PIX_ACK
    } pix_hs_e;

    // Output side four-phase states
    typedef enum logic [1:0] {
        RES_IDLE,
        RES_REQ,
        RES_RELEASE
    } res_hs_e;

    typedef logic [3:0] fifo_cnt_t;

    typedef struct packed {
        fifo_cnt_t free;   // Slots still open
        logic      empty;
    } fifo_status_t;

endpackage

`default_nettype wire

// ==== source/cnn_data_pkg.sv ====
`default_nettype none

`include "cnn_conv_defines.svh"

package cnn_data_pkg;

    // =======================================================================
    // Scalar widths
    // =======================================================================
    typedef logic signed [`CNN_PIX_BW-1:0] pixel_t;
    typedef logic signed [`CNN_W_BW-1:0]   weight_t;
    typedef logic signed [`CNN_B_BW-1:0]   bias_t;
    typedef logic signed [`CNN_M_BW-1:0]   product_t;
    typedef logic signed [`CNN_ACC_BW-1:0] acc_t;

    // Unsigned after ReLU and saturation
    typedef logic [`CNN_OUT_BW-1:0] result_t;

    // =======================================================================
    // Window and weight sets
    // =======================================================================

    // Row-major, element row*KX+col, col 0 is the oldest column
    typedef struct packed {
        pixel_t [`CNN_KY*`CNN_KX-1:0] px;
    } window_t;

    // Same ordering as the window
    typedef struct packed {
        weight_t [`CNN_KY*`CNN_KX-1:0] w;
    } weights_t;

endpackage

`default_nettype wire

// ==== source/cnn_conv_defines.svh ====
`ifndef CNN_CONV_DEFINES_SVH
`define CNN_CONV_DEFINES_SVH

// ===========================================================================
// Kernel and frame geometry
// ===========================================================================
`define CNN_KX          5
`define CNN_KY          5
`define CNN_IMG_W       8
`define CNN_IMG_H       8

// ===========================================================================
// Datapath widths
// ===========================================================================
`define CNN_PIX_BW      8   // Input feature
`define CNN_W_BW        8   // Kernel weight
`define CNN_B_BW        16  // Bias
`define CNN_M_BW        16  // Pixel times weight
`define CNN_ACC_BW      21  // Product width plus log2 of 25 taps
`define CNN_OUT_BW      8   // Output pixel

// Output scaling before ReLU
`define CNN_OUT_SHIFT   6

// Window valid to sum valid, in cycles
`define CNN_KERNEL_LAT  2

`endif
